/* common/cache_pkg.sv */
`default_nettype none

package cache_pkg;

	// Byte address width
	localparam int addr_w = 32;

	// Tree pseudo-LRU below is written for exactly four ways
	localparam int ways = 4;

	typedef logic [$clog2(ways)-1:0] way_sel_t;

	// Miss handling sequence
	typedef enum logic [1:0] {
		st_idle,
		st_write_back,
		st_fill,
		st_settle
	} ctrl_state_t;

endpackage

`default_nettype wire

/* common/fill_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface fill_if #(
	parameter int width = 128,
	parameter int depth = 4
);
	import cache_pkg::*;

	localparam int off_w = $clog2(width / 8);
	localparam int idx_w = $clog2(depth);
	localparam int tag_w = addr_w - off_w - idx_w;

	// Line fill, valid for one cycle
	logic fill_valid;
	way_sel_t fill_way;
	logic [idx_w-1:0] fill_index;
	logic [tag_w-1:0] fill_tag;
	logic [width-1:0] fill_data;
	way_sel_t victim_way;

	// One slot per way, zero unless that way is the victim
	wire [ways-1:0] victim_dirty;
	wire [ways-1:0][tag_w-1:0] victim_tag;
	wire [ways-1:0][width-1:0] victim_line;

	modport controller (
		output fill_valid, fill_way, fill_index, fill_tag, fill_data, victim_way,
		input victim_dirty, victim_tag, victim_line
	);

	modport way (
		input fill_valid, fill_way, fill_index, fill_tag, fill_data, victim_way,
		output victim_dirty, victim_tag, victim_line
	);

endinterface

`default_nettype wire

/* cache/cache_way.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_way #(
	parameter int width = 128,
	parameter int depth = 4,
	parameter int way_id = 0
) (
	input wire clk,
	input wire reset,
	input wire [cache_pkg::addr_w-1:0] addr,
	input wire lookup_write,
	input wire [width/8-1:0] byte_enable,
	input wire [width-1:0] data_in,
	output logic way_hit,
	output logic way_valid,
	output logic [width-1:0] line_out,
	fill_if.way fill
);
	import cache_pkg::*;

	localparam int bytes = width / 8;
	localparam int off_w = $clog2(bytes);
	localparam int idx_w = $clog2(depth);
	localparam int tag_w = addr_w - off_w - idx_w;

	logic [depth-1:0] valid;
	logic [depth-1:0] dirty;
	logic [tag_w-1:0] tags [depth];
	logic [width-1:0] lines [depth];

	logic [idx_w-1:0] index;
	logic [tag_w-1:0] tag;
	logic [width-1:0] bit_mask;
	logic [width-1:0] merged;
	logic fill_here;
	logic write_here;
	logic victim_sel;

	// address = tag | index | offset
	assign index = addr[off_w +: idx_w];
	assign tag = addr[addr_w-1 -: tag_w];

	assign way_valid = valid[index];
	assign way_hit = way_valid && (tags[index] == tag);

	always_comb begin
		for (int b = 0; b < bytes; b++) begin
			bit_mask[8*b +: 8] = {8{byte_enable[b]}};
		end
	end

	assign merged = (lines[index] & ~bit_mask) | (data_in & bit_mask);
	// Write hits report the line as it will be after the merge
	assign line_out = lookup_write ? merged : lines[index];

	assign fill_here = fill.fill_valid && (fill.fill_way == way_sel_t'(way_id));
	assign write_here = lookup_write && way_hit;

	assign victim_sel = (fill.victim_way == way_sel_t'(way_id));
	assign fill.victim_dirty[way_id] = victim_sel && dirty[index];
	assign fill.victim_tag[way_id] = victim_sel ? tags[index] : '0;
	assign fill.victim_line[way_id] = victim_sel ? lines[index] : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
			dirty <= '0;
		end else if (fill_here) begin
			valid[fill.fill_index] <= 1'b1;
			dirty[fill.fill_index] <= 1'b0;
		end else if (write_here) begin
			dirty[index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_here) begin
			tags[fill.fill_index] <= fill.fill_tag;
			lines[fill.fill_index] <= fill.fill_data;
		end else if (write_here) begin
			lines[index] <= merged;
		end
	end

	// Fills only happen while the controller is busy, never alongside a write hit
	fill_vs_write: assert property (@(posedge clk) disable iff (reset)
		!(fill_here && write_here));

endmodule

`default_nettype wire

/* cache/plru_tree.sv */
`timescale 1ns/10ps
`default_nettype none

module plru_tree #(
	parameter int depth = 4
) (
	input wire clk,
	input wire reset,
	input wire [$clog2(depth)-1:0] index,
	input wire [cache_pkg::ways-1:0] way_valid_vec,
	input wire touch,
	input wire cache_pkg::way_sel_t touch_way,
	output cache_pkg::way_sel_t victim_way
);
	import cache_pkg::*;

	// bit 2 picks the pair, bit 1 within ways 0/1, bit 0 within ways 2/3
	logic [depth-1:0][2:0] tree;
	logic [2:0] bits;

	assign bits = tree[index];

	always_ff @(posedge clk) begin
		if (reset) begin
			tree <= '0;
		end else if (touch) begin
			// Point away from the touched way
			case (touch_way)
				2'd0: tree[index] <= {2'b11, bits[0]};
				2'd1: tree[index] <= {2'b10, bits[0]};
				2'd2: tree[index] <= {1'b0, bits[1], 1'b1};
				default: tree[index] <= {1'b0, bits[1], 1'b0};
			endcase
		end
	end

	always_comb begin
		if (!way_valid_vec[0])
			victim_way = 2'd0;
		else if (!way_valid_vec[1])
			victim_way = 2'd1;
		else if (!way_valid_vec[2])
			victim_way = 2'd2;
		else if (!way_valid_vec[3])
			victim_way = 2'd3;
		else if (!bits[2])
			victim_way = bits[1] ? 2'd1 : 2'd0;
		else
			victim_way = bits[0] ? 2'd3 : 2'd2;
	end

endmodule

`default_nettype wire

/* cache/cache_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_controller #(
	parameter int width = 128,
	parameter int depth = 4
) (
	input wire clk,
	input wire reset,
	input wire [cache_pkg::addr_w-1:0] addr,
	input wire read_write,
	input wire master_enable,
	input wire [cache_pkg::ways-1:0] way_hit_vec,
	input wire [cache_pkg::ways-1:0] way_valid_vec,
	input wire [cache_pkg::ways-1:0][width-1:0] line_vec,
	input wire cache_pkg::way_sel_t victim_way,
	output logic touch,
	output cache_pkg::way_sel_t touch_way,
	output logic lookup_write,
	output logic [width-1:0] data_out,
	output logic hit,
	fill_if.controller fill,
	output logic mem_write_req,
	output logic [cache_pkg::addr_w-1:0] mem_write_addr,
	output logic [width-1:0] mem_write_data,
	input wire mem_write_ack,
	output logic mem_read_req,
	output logic [cache_pkg::addr_w-1:0] mem_read_addr,
	input wire mem_read_ack,
	input wire [width-1:0] mem_read_data
);
	import cache_pkg::*;

	localparam int off_w = $clog2(width / 8);
	localparam int idx_w = $clog2(depth);
	localparam int tag_w = addr_w - off_w - idx_w;

	ctrl_state_t state;
	way_sel_t victim_q;
	way_sel_t hit_way;
	logic [idx_w-1:0] index;
	logic lookup_ok;
	logic any_hit;
	logic hit_touch;
	logic miss;
	logic need_wb;

	assign index = addr[off_w +: idx_w];

	// Lookups are only served between misses
	assign lookup_ok = (state == st_idle) && master_enable;
	assign any_hit = |way_hit_vec;
	assign hit_touch = lookup_ok && any_hit;
	assign miss = lookup_ok && !any_hit;
	assign lookup_write = hit_touch && !read_write;

	always_comb begin
		hit_way = '0;
		for (int w = 0; w < ways; w++) begin
			if (way_hit_vec[w])
				hit_way = way_sel_t'(w);
		end
	end

	// Fresh tree choice while idle, the latched victim afterwards
	assign fill.victim_way = (state == st_idle) ? victim_way : victim_q;
	assign need_wb = way_valid_vec[victim_way] && fill.victim_dirty[victim_way];

	assign fill.fill_valid = (state == st_fill) && mem_read_ack;
	assign fill.fill_way = victim_q;
	assign fill.fill_index = mem_read_addr[off_w +: idx_w];
	assign fill.fill_tag = mem_read_addr[addr_w-1 -: tag_w];
	assign fill.fill_data = mem_read_data;

	assign touch = hit_touch || fill.fill_valid;
	assign touch_way = fill.fill_valid ? victim_q : hit_way;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			hit <= 1'b0;
			mem_write_req <= 1'b0;
			mem_read_req <= 1'b0;
			victim_q <= '0;
		end else begin
			hit <= hit_touch;
			case (state)
				st_idle: if (miss) begin
					victim_q <= victim_way;
					if (need_wb) begin
						mem_write_req <= 1'b1;
						state <= st_write_back;
					end else begin
						mem_read_req <= 1'b1;
						state <= st_fill;
					end
				end
				st_write_back: if (mem_write_ack) begin
					mem_write_req <= 1'b0;
					mem_read_req <= 1'b1;
					state <= st_fill;
				end
				st_fill: if (mem_read_ack) begin
					mem_read_req <= 1'b0;
					state <= st_settle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (hit_touch)
			data_out <= line_vec[hit_way];
		if (miss) begin
			mem_read_addr <= {addr[addr_w-1:off_w], {off_w{1'b0}}};
			mem_write_addr <= {fill.victim_tag[victim_way], index, {off_w{1'b0}}};
			mem_write_data <= fill.victim_line[victim_way];
		end
	end

	one_hit: assert property (@(posedge clk) disable iff (reset) $onehot0(way_hit_vec));

	write_req_held: assert property (@(posedge clk) disable iff (reset)
		mem_write_req && !mem_write_ack |=> mem_write_req);

	read_req_held: assert property (@(posedge clk) disable iff (reset)
		mem_read_req && !mem_read_ack |=> mem_read_req);

	// Write-back always finishes before the fill read goes out
	read_after_wb: assert property (@(posedge clk) disable iff (reset)
		!(mem_read_req && mem_write_req));

endmodule

`default_nettype wire

/* source/cache_4way.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_4way #(
	parameter int width = 128,
	parameter int depth = 4
) (
	input wire clk,
	input wire reset,
	input wire [cache_pkg::addr_w-1:0] addr,
	input wire read_write,
	input wire master_enable,
	input wire [width/8-1:0] byte_enable,
	input wire [width-1:0] data_in,
	output wire [width-1:0] data_out,
	output wire hit,
	output wire mem_write_req,
	output wire [cache_pkg::addr_w-1:0] mem_write_addr,
	output wire [width-1:0] mem_write_data,
	input wire mem_write_ack,
	output wire mem_read_req,
	output wire [cache_pkg::addr_w-1:0] mem_read_addr,
	input wire [width-1:0] mem_read_data,
	input wire mem_read_ack
);
	import cache_pkg::*;

	localparam int off_w = $clog2(width / 8);
	localparam int idx_w = $clog2(depth);

	wire [ways-1:0] way_hit_vec;
	wire [ways-1:0] way_valid_vec;
	wire [ways-1:0][width-1:0] line_vec;
	wire [idx_w-1:0] index;
	wire lookup_write;
	wire touch;
	way_sel_t touch_way;
	way_sel_t victim_way;

	assign index = addr[off_w +: idx_w];

	fill_if #(.width(width), .depth(depth)) fill_bus ();

	for (genvar g = 0; g < ways; g++) begin : gen_way
		cache_way #(.width(width), .depth(depth), .way_id(g)) way_i (
			.clk(clk),
			.reset(reset),
			.addr(addr),
			.lookup_write(lookup_write),
			.byte_enable(byte_enable),
			.data_in(data_in),
			.way_hit(way_hit_vec[g]),
			.way_valid(way_valid_vec[g]),
			.line_out(line_vec[g]),
			.fill(fill_bus.way)
		);
	end

	plru_tree #(.depth(depth)) plru_i (
		.clk(clk),
		.reset(reset),
		.index(index),
		.way_valid_vec(way_valid_vec),
		.touch(touch),
		.touch_way(touch_way),
		.victim_way(victim_way)
	);

	cache_controller #(.width(width), .depth(depth)) ctrl_i (
		.clk(clk),
		.reset(reset),
		.addr(addr),
		.read_write(read_write),
		.master_enable(master_enable),
		.way_hit_vec(way_hit_vec),
		.way_valid_vec(way_valid_vec),
		.line_vec(line_vec),
		.victim_way(victim_way),
		.touch(touch),
		.touch_way(touch_way),
		.lookup_write(lookup_write),
		.data_out(data_out),
		.hit(hit),
		.fill(fill_bus.controller),
		.mem_write_req(mem_write_req),
		.mem_write_addr(mem_write_addr),
		.mem_write_data(mem_write_data),
		.mem_write_ack(mem_write_ack),
		.mem_read_req(mem_read_req),
		.mem_read_addr(mem_read_addr),
		.mem_read_ack(mem_read_ack),
		.mem_read_data(mem_read_data)
	);

endmodule

`default_nettype wire

/* test/mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_model #(
	parameter int width = 128
) (
	input wire clk,
	input wire reset,
	input wire write_req,
	input wire [31:0] write_addr,
	input wire [width-1:0] write_data,
	output wire write_ack,
	input wire read_req,
	input wire [31:0] read_addr,
	output wire [width-1:0] read_data,
	output wire read_ack,
	output logic [31:0] last_wb_addr,
	output logic [width-1:0] last_wb_data
);
	logic [width-1:0] store [logic [31:0]];
	logic write_ack_q = 1'b0;
	logic read_ack_q = 1'b0;
	logic [width-1:0] read_data_q = '0;
	int write_wait;
	int read_wait;

	assign write_ack = write_ack_q;
	assign read_ack = read_ack_q;
	assign read_data = read_data_q;

	// Untouched lines hold a pattern of their own address
	function automatic logic [width-1:0] initial_line(input logic [31:0] line_addr);
		return width'({line_addr ^ 32'h3333_3333, ~line_addr, line_addr ^ 32'h5555_5555, line_addr});
	endfunction

	always @(posedge clk) begin
		write_ack_q <= 1'b0;
		read_ack_q <= 1'b0;
		if (reset) begin
			write_wait <= 0;
			read_wait <= 0;
		end else begin
			if (write_req && !write_ack_q) begin
				if (write_wait == 0) begin
					write_wait <= $urandom_range(5, 1);
				end else if (write_wait == 1) begin
					store[write_addr] = write_data;
					last_wb_addr <= write_addr;
					last_wb_data <= write_data;
					write_ack_q <= 1'b1;
					write_wait <= 0;
				end else begin
					write_wait <= write_wait - 1;
				end
			end
			if (read_req && !read_ack_q) begin
				if (read_wait == 0) begin
					read_wait <= $urandom_range(5, 1);
				end else if (read_wait == 1) begin
					read_data_q <= store.exists(read_addr) ? store[read_addr]
						: initial_line(read_addr);
					read_ack_q <= 1'b1;
					read_wait <= 0;
				end else begin
					read_wait <= read_wait - 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* test/tb_cache.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_cache;
	localparam int width = 128;
	localparam int depth = 4;
	localparam int bytes = width / 8;
	localparam int max_accesses = 40;
	localparam int max_access_cycles = 40;
	// Twice the worst case plus slack
	localparam int timeout_cycles = 2 * max_accesses * max_access_cycles + 800;

	logic clk = 1'b0;
	logic reset;
	logic [31:0] addr;
	logic read_write;
	logic master_enable;
	logic [bytes-1:0] byte_enable;
	logic [width-1:0] data_in;
	wire [width-1:0] data_out;
	wire hit;
	wire mem_write_req;
	wire [31:0] mem_write_addr;
	wire [width-1:0] mem_write_data;
	wire mem_write_ack;
	wire mem_read_req;
	wire [31:0] mem_read_addr;
	wire [width-1:0] mem_read_data;
	wire mem_read_ack;
	wire [31:0] last_wb_addr;
	wire [width-1:0] last_wb_data;

	logic [width-1:0] shadow [logic [31:0]];
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	logic started = 1'b0;

	// Memory traffic seen during the last access
	int latency;
	int read_reqs;
	logic read_prev;
	logic wb_seen;
	logic wb_before_read;
	logic [31:0] wb_addr;
	logic [width-1:0] wb_data;
	logic [31:0] fill_addr;

	always #5 clk = ~clk;

	cache_4way #(.width(width), .depth(depth)) cache_4way_i (
		.clk(clk),
		.reset(reset),
		.addr(addr),
		.read_write(read_write),
		.master_enable(master_enable),
		.byte_enable(byte_enable),
		.data_in(data_in),
		.data_out(data_out),
		.hit(hit),
		.mem_write_req(mem_write_req),
		.mem_write_addr(mem_write_addr),
		.mem_write_data(mem_write_data),
		.mem_write_ack(mem_write_ack),
		.mem_read_req(mem_read_req),
		.mem_read_addr(mem_read_addr),
		.mem_read_data(mem_read_data),
		.mem_read_ack(mem_read_ack)
	);

	mem_model #(.width(width)) mem_i (
		.clk(clk),
		.reset(reset),
		.write_req(mem_write_req),
		.write_addr(mem_write_addr),
		.write_data(mem_write_data),
		.write_ack(mem_write_ack),
		.read_req(mem_read_req),
		.read_addr(mem_read_addr),
		.read_data(mem_read_data),
		.read_ack(mem_read_ack),
		.last_wb_addr(last_wb_addr),
		.last_wb_data(last_wb_data)
	);

	// tag | index | 16-byte offset
	function automatic logic [31:0] line_addr(input int tag, input int index);
		return {tag[25:0], index[1:0], 4'b0000};
	endfunction

	function automatic logic [width-1:0] expected_line(input logic [31:0] a);
		if (shadow.exists(a))
			return shadow[a];
		return {a ^ 32'h3333_3333, ~a, a ^ 32'h5555_5555, a};
	endfunction

	function automatic logic [width-1:0] merge(input logic [width-1:0] old,
			input logic [width-1:0] d, input logic [bytes-1:0] be);
		logic [width-1:0] line;
		line = old;
		for (int b = 0; b < bytes; b++) begin
			if (be[b])
				line[8*b +: 8] = d[8*b +: 8];
		end
		return line;
	endfunction

	function automatic logic [width-1:0] random_line();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	task automatic check_value(input string name, input logic [width-1:0] expected,
			input logic [width-1:0] actual);
		checks++;
		assert (actual === expected)
		else begin
			errors++;
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_true(input string name, input logic cond, input string what);
		checks++;
		assert (cond)
		else begin
			errors++;
			$display("%s failed: %s", name, what);
		end
	endtask

	// One request held until hit, then one idle cycle
	task automatic access(input string name, input logic [31:0] a, input logic rd,
			input logic [bytes-1:0] be, input logic [width-1:0] d);
		logic [width-1:0] expected;
		expected = rd ? expected_line(a) : merge(expected_line(a), d, be);
		latency = 0;
		read_reqs = 0;
		read_prev = 1'b0;
		wb_seen = 1'b0;
		wb_before_read = 1'b0;
		started <= 1'b1;
		addr <= a;
		read_write <= rd;
		byte_enable <= be;
		data_in <= d;
		master_enable <= 1'b1;
		do begin
			@(posedge clk);
			latency++;
			if (mem_write_req && !wb_seen) begin
				wb_seen = 1'b1;
				wb_addr = mem_write_addr;
				wb_data = mem_write_data;
			end
			if (mem_read_req && !read_prev) begin
				read_reqs++;
				fill_addr = mem_read_addr;
				wb_before_read = wb_seen;
			end
			read_prev = mem_read_req;
		end while (!hit);
		check_value(name, expected, data_out);
		if (wb_seen)
			check_value({name, " write-back"}, expected_line(wb_addr), wb_data);
		if (!rd)
			shadow[a] = expected;
		master_enable <= 1'b0;
		@(posedge clk);
	endtask

	quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
		!started |-> !hit && !mem_read_req && !mem_write_req)
		else begin
			errors++;
			$display("Cache raised hit or a memory request before the first access");
		end

	hit_needs_request: assert property (@(posedge clk) disable iff (reset)
		!$past(master_enable) |-> !hit)
		else begin
			errors++;
			$display("hit was high although master_enable was low the cycle before");
		end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= timeout_cycles) begin
			$display("Timeout: run still busy after %0d cycles", cycles);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial begin
		int tag;
		int index;
		logic rd;
		void'($urandom(94));
		reset = 1'b1;
		master_enable = 1'b0;
		addr = '0;
		read_write = 1'b1;
		byte_enable = '0;
		data_in = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		repeat (5) @(posedge clk);

		access("read_miss", line_addr(1, 0), 1'b1, '0, '0);
		check_true("read_miss", read_reqs == 1 && !wb_seen, "expected one read and no write-back");
		check_value("read_miss address", line_addr(1, 0), fill_addr);

		access("read_hit", line_addr(1, 0), 1'b1, '0, '0);
		check_true("read_hit", read_reqs == 0 && !wb_seen, "a hit went out to memory");
		// Driven on one edge, looked up on the next, seen registered on the one after
		check_value("read_hit latency", 2, latency);

		access("write_hit", line_addr(1, 0), 1'b0, bytes'($urandom), random_line());
		access("read_after_write", line_addr(1, 0), 1'b1, '0, '0);

		for (int t = 10; t < 14; t++)
			access("set_fill", line_addr(t, 1), 1'b1, '0, '0);
		// Fills landed in ways 0 to 3, touch 2, 0, 3, 1 so the tree points at way 2
		access("touch_way2", line_addr(12, 1), 1'b0, bytes'($urandom), random_line());
		access("touch_way0", line_addr(10, 1), 1'b1, '0, '0);
		access("touch_way3", line_addr(13, 1), 1'b1, '0, '0);
		access("touch_way1", line_addr(11, 1), 1'b1, '0, '0);
		access("evict", line_addr(14, 1), 1'b1, '0, '0);
		check_true("evict", wb_seen && wb_before_read, "dirty victim not written back before fill");
		check_value("evict victim address", line_addr(12, 1), wb_addr);
		check_value("evict fill address", line_addr(14, 1), fill_addr);
		check_value("evict memory log address", line_addr(12, 1), last_wb_addr);
		check_value("evict memory log", expected_line(line_addr(12, 1)), last_wb_data);
		access("reread_victim", line_addr(12, 1), 1'b1, '0, '0);
		check_true("reread_victim", read_reqs == 1, "evicted line did not miss");

		for (int n = 0; n < 24; n++) begin
			tag = 20 + $urandom_range(7, 0);
			index = $urandom_range(3, 0);
			rd = 1'($urandom_range(1, 0));
			access(rd ? "random_read" : "random_write", line_addr(tag, index), rd,
				bytes'($urandom), random_line());
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
common/cache_pkg.sv
common/fill_if.sv
cache/cache_way.sv
cache/plru_tree.sv
cache/cache_controller.sv
source/cache_4way.sv
test/mem_model.sv
test/tb_cache.sv

/* Makefile */
VERILATOR ?= verilator
TOP := tb_cache
FILELIST := sim.f
BUILD_DIR := obj_dir
LOG := sim.log
PASS_TEXT := Result: PASSED
LINT_FLAGS := --lint-only --timing --assert -Wno-fatal
SIM_FLAGS := --binary --timing --assert -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
